// File: verilog/rom_cfg.svh
/*
 * build-time settings of the rom access subsystem
 * address widths, where the sprite rom sits in sdram, reload delay
 * included by the package and by every module that sizes a port from it
 */
`ifndef ROM_CFG_SVH
`define ROM_CFG_SVH

// client side address widths
`define MAIN_AW      15      // main cpu byte address, 32 kB program rom
`define OBJ_AW       13      // object engine 32-bit word address, 32 kB

// sdram side
`define SDRAM_AW     22      // 16-bit word address
`define OBJ_OFFSET   16384   // first sdram word of the sprite rom

// cycles from the end of a reload until ready goes high
`define READY_DELAY  4

// program rom is stored byte swapped inside each 16-bit word
// 1'b1 flips address bit 0 in the byte select, 1'b0 keeps linear order
`define MAIN_SWAP_A0 1'b1

`endif

// File: verilog/rom_pkg.sv
/*
 * types shared across the rom bus
 * client payloads, the one-hot client select and the sdram command
 * modules import it inside the body, ports use scoped names
 */
`include "rom_cfg.svh"

package rom_pkg;

    // one sdram read returns two 16-bit words
    typedef logic [31:0] line_t;   // byte 0 in bits 7:0

    typedef logic [7:0]  byte_t;   // main cpu payload
    typedef logic [31:0] word_t;   // object engine payload, a full line

    // which client a read belongs to
    typedef logic [1:0] client_t;  // one-hot

    localparam int CLIENT_MAIN = 0;
    localparam int CLIENT_OBJ  = 1;

    // command towards the sdram controller
    typedef struct packed {
        logic                 req;   // level, dropped after ack
        logic [`SDRAM_AW-1:0] addr;  // held until data_rdy
    } sdram_cmd_t;

endpackage

// File: verilog/rom_request.sv
/*
 * one-line read cache sitting between a rom client and the arbiter
 * a hit answers in the same cycle; a miss holds req until the fill pulse
 * data_t sets the payload: a slice of the line or the whole line
 */
`timescale 1ns/10ps
`include "rom_cfg.svh"

module rom_request #(
    type data_t = rom_pkg::byte_t,
    parameter int AW = `MAIN_AW,
    localparam int DW = $bits(data_t),                    // payload width
    localparam int OW = $clog2($bits(rom_pkg::line_t) / DW)  // offset bits in line
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clear,     // reload in progress, drop the line
    input  logic [AW-1:0]    addr,
    input  logic             addr_ok,   // client really wants addr
    input  rom_pkg::line_t   din,       // sdram read data
    input  logic             fill,      // one-cycle write strobe from arbiter
    output logic             req,       // miss pending
    output logic [AW-OW-1:0] tag,       // line index of the pending miss
    output data_t            dout,
    output logic             data_ok    // dout valid this cycle
);
    import rom_pkg::*;

    line_t            line_q;    // cached line
    logic [AW-OW-1:0] line_tag;  // its line index
    logic             valid;
    logic [AW-OW-1:0] req_tag;   // line index latched with the miss
    logic [AW-OW-1:0] addr_tag;
    logic             hit;
    logic             miss;
    logic             req_q;
    logic             new_miss;

    assign addr_tag = addr[AW-1:OW];   // drop in-line offset

    // same-cycle hit check against the one cached line
    assign hit      = addr_ok && valid && (line_tag == addr_tag);
    assign miss     = addr_ok && !hit;
    assign new_miss = miss && !req_q;  // only the first cycle of a miss

    // valid and req are control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
            req_q <= 1'b0;
        end else if (clear) begin
            valid <= 1'b0;   // rom contents may change during reload
            req_q <= 1'b0;   // arbiter forgets the request too
        end else if (fill) begin
            valid <= 1'b1;
            req_q <= 1'b0;   // served
        end else if (new_miss) begin
            req_q <= 1'b1;   // hold until fill
        end
    end

    // the tag is frozen while the request waits, so the
    // arbiter maps a stable address even if the client moves on
    always_ff @(posedge clk) begin
        if (new_miss) begin
            req_tag <= addr_tag;
        end
        if (fill) begin
            line_q   <= din;
            line_tag <= req_tag;   // what was asked for, not current addr
        end
    end

    // payload select
    generate
        if (OW == 0) begin : g_line
            // payload as wide as the line
            assign dout = data_t'(line_q);
        end else begin : g_slice
            logic [OW-1:0] sel;

            // swapped storage flips a0
            assign sel  = addr[OW-1:0] ^ OW'(`MAIN_SWAP_A0);
            assign dout = data_t'(line_q[sel*DW +: DW]);
        end
    endgenerate

    assign req     = req_q;
    assign tag     = req_tag;
    assign data_ok = hit;   // ok one cycle after fill, or straight on a hit

endmodule

// File: verilog/rom_arbiter.sv
/*
 * arbiter for the shared sdram port of the two rom caches
 * serves one miss at a time, object client first, maps client line
 * indexes to sdram word addresses and runs the ready delay after reload
 */
`timescale 1ns/10ps
`include "rom_cfg.svh"

module rom_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                downloading,   // rom download running
    input  logic                loop_rst,      // game loop reset
    input  logic                main_req,
    input  logic                obj_req,
    input  logic [`MAIN_AW-3:0] main_tag,      // 4 bytes per line
    input  logic [`OBJ_AW-1:0]  obj_tag,       // one word per line
    input  logic                sdram_ack,
    input  logic                data_rdy,      // read data valid, one cycle
    output logic                main_fill,
    output logic                obj_fill,
    output logic                clear,         // to both caches
    output rom_pkg::sdram_cmd_t sdram_cmd,
    output logic                ready
);
    import rom_pkg::*;

    localparam logic [`SDRAM_AW-1:0] OBJ_BASE = `SDRAM_AW'(`OBJ_OFFSET);
    localparam int CW = $clog2(`READY_DELAY + 1);   // ready counter width

    client_t              in_svc;     // client whose read is outstanding
    client_t              pending;    // requests not yet being served
    client_t              grant;
    logic                 accept;     // free to take a new miss
    logic                 req_q;
    logic [`SDRAM_AW-1:0] addr_q;
    logic [`SDRAM_AW-1:0] main_map;
    logic [`SDRAM_AW-1:0] obj_map;
    logic [`SDRAM_AW-1:0] next_addr;
    logic [CW-1:0]        ready_cnt;

    // sync clear: download or loop reset
    assign clear = downloading | loop_rst;

    // a client in service keeps req high until its fill, mask it
    assign pending = client_t'({obj_req, main_req}) & ~in_svc;

    // idle, or the current read completes this cycle
    assign accept = (in_svc == '0) || data_rdy;

    // address mapping, one sdram read = two 16-bit words
    assign main_map = `SDRAM_AW'({main_tag, 1'b0});
    assign obj_map  = OBJ_BASE + `SDRAM_AW'({obj_tag, 1'b0});  // past program rom

    // fixed priority, obj first
    always_comb begin
        grant     = '0;
        next_addr = addr_q;   // hold when nothing to take
        if (pending[CLIENT_OBJ]) begin
            grant[CLIENT_OBJ] = 1'b1;
            next_addr         = obj_map;
        end else if (pending[CLIENT_MAIN]) begin
            grant[CLIENT_MAIN] = 1'b1;
            next_addr          = main_map;
        end
    end

    // request level and service owner
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q  <= 1'b0;
            in_svc <= '0;
        end else if (clear) begin
            req_q  <= 1'b0;
            in_svc <= '0;
        end else begin
            if (sdram_ack) begin
                req_q <= 1'b0;    // low the cycle after ack
            end
            if (accept) begin
                req_q  <= |pending;   // overrides the ack drop
                in_svc <= grant;      // zero when nothing pending
            end
        end
    end

    // command address, stable from accept until data_rdy
    always_ff @(posedge clk) begin
        if (accept && !clear) begin
            addr_q <= next_addr;
        end
    end

    assign sdram_cmd = '{req: req_q, addr: addr_q};

    // write strobe into the cache that owns the read
    assign main_fill = data_rdy & in_svc[CLIENT_MAIN];
    assign obj_fill  = data_rdy & in_svc[CLIENT_OBJ];

    // ready delay
    // counts the clock edges after clear has gone low, ready set on the
    // READY_DELAY-th one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready     <= 1'b0;
            ready_cnt <= '0;
        end else if (clear) begin
            ready     <= 1'b0;
            ready_cnt <= '0;
        end else if (!ready) begin
            if (ready_cnt == CW'(`READY_DELAY - 1)) begin
                ready <= 1'b1;   // stays until next clear
            end else begin
                ready_cnt <= ready_cnt + 1'b1;
            end
        end
    end

endmodule

// File: verilog/rom_bus_top.sv
/*
 * rom access subsystem top
 * program rom cache, sprite rom cache and the arbiter on one sdram port
 * the sdram controller itself sits outside, on sdram_cmd / ack / data_rdy
 */
`timescale 1ns/10ps
`include "rom_cfg.svh"

module rom_bus_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                downloading,
    input  logic                loop_rst,
    // main cpu, program rom
    input  logic [`MAIN_AW-1:0] main_addr,
    input  logic                main_cs,
    output rom_pkg::byte_t      main_dout,
    output logic                main_ok,
    // object engine, sprite rom, always enabled
    input  logic [`OBJ_AW-1:0]  obj_addr,
    output rom_pkg::word_t      obj_dout,
    output logic                obj_ok,
    output logic                ready,
    // sdram port
    output rom_pkg::sdram_cmd_t sdram_cmd,
    input  logic                sdram_ack,
    input  logic                data_rdy,
    input  rom_pkg::line_t      data_read
);

    logic                main_req;
    logic                obj_req;
    logic [`MAIN_AW-3:0] main_tag;   // byte address without line offset
    logic [`OBJ_AW-1:0]  obj_tag;    // whole word address
    logic                main_fill;
    logic                obj_fill;
    logic                clear;

    rom_request #(
        .data_t  ( rom_pkg::byte_t ),
        .AW      ( `MAIN_AW        )
    ) u_main (
        .clk     ( clk       ),
        .rst_n   ( rst_n     ),
        .clear   ( clear     ),
        .addr    ( main_addr ),
        .addr_ok ( main_cs   ),
        .din     ( data_read ),
        .fill    ( main_fill ),
        .req     ( main_req  ),
        .tag     ( main_tag  ),
        .dout    ( main_dout ),
        .data_ok ( main_ok   )
    );

    rom_request #(
        .data_t  ( rom_pkg::word_t ),
        .AW      ( `OBJ_AW         )
    ) u_obj (
        .clk     ( clk       ),
        .rst_n   ( rst_n     ),
        .clear   ( clear     ),
        .addr    ( obj_addr  ),
        .addr_ok ( 1'b1      ),   // engine reads every cycle
        .din     ( data_read ),
        .fill    ( obj_fill  ),
        .req     ( obj_req   ),
        .tag     ( obj_tag   ),
        .dout    ( obj_dout  ),
        .data_ok ( obj_ok    )
    );

    rom_arbiter u_arbiter (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .loop_rst    ( loop_rst    ),
        .main_req    ( main_req    ),
        .obj_req     ( obj_req     ),
        .main_tag    ( main_tag    ),
        .obj_tag     ( obj_tag     ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .main_fill   ( main_fill   ),
        .obj_fill    ( obj_fill    ),
        .clear       ( clear       ),
        .sdram_cmd   ( sdram_cmd   ),
        .ready       ( ready       )
    );

endmodule

// File: test/sdram_model.sv
/*
 * behavioral sdram for the rom bus testbench
 * acks a pending req after 1..6 cycles, returns a line 1..6 cycles later
 * line contents are a fixed function of the word address
 */
`timescale 1ns/10ps
`include "rom_cfg.svh"

module sdram_model #(
    parameter logic [31:0] SEED = 32'd6332
) (
    input  logic                clk,
    input  logic                rst_n,
    input  rom_pkg::sdram_cmd_t cmd,
    input  logic                hold_ack,   // stall before ack, back-pressure
    output logic                sdram_ack,
    output logic                data_rdy,
    output rom_pkg::line_t      data_read,
    output logic                busy
);
    import rom_pkg::*;

    logic [31:0]          rnd;
    logic [`SDRAM_AW-1:0] addr_l;   // address taken at ack
    int                   d;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // one 16-bit word of rom content
    function automatic logic [15:0] word16(input logic [`SDRAM_AW-1:0] a);
        return a[15:0] ^ 16'h9e37 ^ {a[21:16], 10'd0};
    endfunction

    initial begin
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        busy      = 1'b0;
        rnd       = SEED;
        addr_l    = '0;
        forever begin
            @(posedge clk);
            if (rst_n && cmd.req && !hold_ack) begin
                busy <= 1'b1;
                rnd = xorshift32(rnd);
                d = 1 + int'(rnd % 32'd6);
                repeat (d - 1) @(posedge clk);
                addr_l = cmd.addr;
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack <= 1'b0;
                rnd = xorshift32(rnd);
                d = 1 + int'(rnd % 32'd6);
                repeat (d - 1) @(posedge clk);
                data_read <= {word16(addr_l + 1'b1), word16(addr_l)};  // low word first
                data_rdy  <= 1'b1;
                @(posedge clk);
                data_rdy <= 1'b0;
                busy     <= 1'b0;
            end
        end
    end

endmodule

// File: test/rom_bus_checker.sv
/*
 * data checker for the rom bus
 * whenever a client reports ok, its payload is compared with the value
 * expected from the address mapping and the sdram content function
 */
`timescale 1ns/10ps
`include "rom_cfg.svh"

module rom_bus_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`MAIN_AW-1:0] main_addr,
    input  logic                main_ok,
    input  rom_pkg::byte_t      main_dout,
    input  logic [`OBJ_AW-1:0]  obj_addr,
    input  logic                obj_ok,
    input  rom_pkg::word_t      obj_dout,
    output int                  errors
);
    import rom_pkg::*;

    int err_cnt = 0;

    assign errors = err_cnt;

    function automatic logic [15:0] word16(input logic [`SDRAM_AW-1:0] a);
        return a[15:0] ^ 16'h9e37 ^ {a[21:16], 10'd0};
    endfunction

    function automatic line_t line_at(input logic [`SDRAM_AW-1:0] a);
        return {word16(a + 1'b1), word16(a)};
    endfunction

    // reference for main: line index doubled, a0 flipped in the byte select
    function automatic byte_t main_expect(input logic [`MAIN_AW-1:0] a);
        line_t       l;
        logic [1:0]  sel;
        l   = line_at({8'd0, a[14:2], 1'b0});
        sel = a[1:0] ^ {1'b0, `MAIN_SWAP_A0};
        return l[sel*8 +: 8];
    endfunction

    function automatic word_t obj_expect(input logic [`OBJ_AW-1:0] a);
        return line_at(`SDRAM_AW'(`OBJ_OFFSET) + {8'd0, a, 1'b0});
    endfunction

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_n && main_ok && main_dout !== main_expect(main_addr)) begin
            err_cnt++;
            $display("CHECK FAILED main_dout addr %h got %h expected %h",
                     main_addr, main_dout, main_expect(main_addr));
        end
        if (rst_n && obj_ok && obj_dout !== obj_expect(obj_addr)) begin
            err_cnt++;
            $display("CHECK FAILED obj_dout addr %h got %h expected %h",
                     obj_addr, obj_dout, obj_expect(obj_addr));
        end
    end

endmodule

// File: test/rom_bus_assert.sv
/*
 * protocol assertions on the arbiter's sdram side
 * bound into every rom_arbiter instance
 */
`timescale 1ns/10ps
`include "rom_cfg.svh"

module rom_bus_assert (
    input logic                clk,
    input logic                rst_n,
    input logic                clear,
    input logic                main_req,
    input logic                obj_req,
    input rom_pkg::sdram_cmd_t sdram_cmd,
    input logic                sdram_ack,
    input rom_pkg::client_t    in_svc
);
    import rom_pkg::*;

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n || clear)
        sdram_cmd.req && $past(sdram_cmd.req) |-> $stable(sdram_cmd.addr))
        else $error("sdram address moved while req was high");

    // one client at a time, and only one whose cache still asks
    a_one_client: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(in_svc) && ((in_svc & ~client_t'({obj_req, main_req})) == '0))
        else $error("client in service is not a single requesting client");

    a_req_after_ack: assert property (@(posedge clk) disable iff (!rst_n || clear)
        sdram_ack |=> !sdram_cmd.req)
        else $error("req still high after sdram_ack");

endmodule

bind rom_arbiter rom_bus_assert u_assert (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .clear     ( clear     ),
    .main_req  ( main_req  ),
    .obj_req   ( obj_req   ),
    .sdram_cmd ( sdram_cmd ),
    .sdram_ack ( sdram_ack ),
    .in_svc    ( in_svc    )
);

// File: test/rom_bus_tb.sv
/*
 * testbench for the rom bus top level
 * random reads from small windows, then priority, hit, reload and stall cases
 * data is checked by rom_bus_checker, sequencing here
 */
`timescale 1ns/10ps
`include "rom_cfg.svh"

module rom_bus_tb;
    import rom_pkg::*;

    localparam int N_RAND   = 200;
    localparam int WD_LIMIT = (N_RAND + 40) * 20 + 500;   // cycles

    logic                clk;
    logic                rst_n;
    logic                downloading;
    logic                loop_rst;
    logic [`MAIN_AW-1:0] main_addr;
    logic                main_cs;
    byte_t               main_dout;
    logic                main_ok;
    logic [`OBJ_AW-1:0]  obj_addr;
    word_t               obj_dout;
    logic                obj_ok;
    logic                ready;
    sdram_cmd_t          sdram_cmd;
    logic                sdram_ack;
    logic                data_rdy;
    line_t               data_read;
    logic                hold_ack;
    logic                busy;
    int                  data_errors;
    int                  seq_errors = 0;
    int                  req_rises  = 0;
    logic                req_prev   = 1'b0;
    logic [31:0]         rnd        = 32'd6332;

    rom_bus_top i_rom_bus_top (
        .clk(clk), .rst_n(rst_n), .downloading(downloading), .loop_rst(loop_rst),
        .main_addr(main_addr), .main_cs(main_cs), .main_dout(main_dout),
        .main_ok(main_ok), .obj_addr(obj_addr), .obj_dout(obj_dout), .obj_ok(obj_ok),
        .ready(ready), .sdram_cmd(sdram_cmd), .sdram_ack(sdram_ack),
        .data_rdy(data_rdy), .data_read(data_read)
    );

    sdram_model u_sdram (
        .clk(clk), .rst_n(rst_n), .cmd(sdram_cmd), .hold_ack(hold_ack),
        .sdram_ack(sdram_ack), .data_rdy(data_rdy), .data_read(data_read), .busy(busy)
    );

    rom_bus_checker u_checker (
        .clk(clk), .rst_n(rst_n), .main_addr(main_addr), .main_ok(main_ok),
        .main_dout(main_dout), .obj_addr(obj_addr), .obj_ok(obj_ok),
        .obj_dout(obj_dout), .errors(data_errors)
    );

    always #50 clk = ~clk;   // 100 ns period

    // rising edges of the sdram request level
    always @(negedge clk) begin
        if (sdram_cmd.req && !req_prev) req_rises++;
        req_prev = sdram_cmd.req;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic drive(input logic [`MAIN_AW-1:0] ma, input logic cs,
                         input logic [`OBJ_AW-1:0] oa);
        @(posedge clk);
        main_addr <= ma;
        main_cs   <= cs;
        obj_addr  <= oa;
    endtask

    // both clients answered, or give up
    task automatic wait_ok();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(obj_ok && (!main_cs || main_ok)) && n < 60);
        if (n >= 60) begin
            seq_errors++;
            $display("timeout waiting for client ok, main %h obj %h", main_addr, obj_addr);
        end
    endtask

    task automatic wait_idle();
        int quiet;
        int n;
        quiet = 0;
        n = 0;
        while (quiet < 3 && n < 200) begin
            @(negedge clk);
            if (!busy && !sdram_cmd.req) quiet++;
            else quiet = 0;
            n++;
        end
        if (quiet < 3) begin
            seq_errors++;
            $display("sdram port never went idle");
        end
    endtask

    initial begin
        sdram_cmd_t held;
        int         rises0;

        clk         = 1'b0;
        rst_n       = 1'b0;
        downloading = 1'b0;
        loop_rst    = 1'b0;
        main_addr   = '0;
        main_cs     = 1'b0;
        obj_addr    = '0;
        hold_ack    = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // random reads, small windows so lines get reused
        for (int i = 0; i < N_RAND; i++) begin
            rnd = xorshift32(rnd);
            drive(15'h0100 + {9'd0, rnd[5:0]}, rnd[16], 13'h0040 + {9'd0, rnd[11:8]});
            wait_ok();
        end

        // simultaneous misses, obj goes first
        wait_idle();
        drive(15'h7000, 1'b1, 13'h1800);
        do @(negedge clk); while (!sdram_cmd.req);
        if (sdram_cmd.addr !== `SDRAM_AW'(`OBJ_OFFSET) + {8'd0, 13'h1800, 1'b0}) begin
            seq_errors++;
            $display("CHECK FAILED sdram_cmd.addr got %h expected %h", sdram_cmd.addr,
                     `SDRAM_AW'(`OBJ_OFFSET) + {8'd0, 13'h1800, 1'b0});
        end
        wait_ok();

        // same line again, no new request
        drive(15'h0200, 1'b1, 13'h1800);
        wait_ok();
        wait_idle();
        rises0 = req_rises;
        for (int j = 1; j < 4; j++) begin
            @(posedge clk);
            main_addr <= 15'h0200 ^ 15'(j);
            @(negedge clk);
            if (!main_ok) begin
                seq_errors++;
                $display("no hit for address %h inside cached line", main_addr);
            end
        end
        if (req_rises != rises0) begin
            seq_errors++;
            $display("CHECK FAILED req rises got %h expected %h", req_rises, rises0);
        end

        // reload drops ready and req, then ready after the delay
        // an obj miss waits on a held-off ack so req is high going in
        @(posedge clk);
        hold_ack <= 1'b1;
        drive(15'h0203, 1'b1, 13'h1900);
        do @(negedge clk); while (!sdram_cmd.req);
        @(posedge clk);
        downloading <= 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (ready || sdram_cmd.req) begin
            seq_errors++;
            $display("ready or req still high during download");
        end
        @(posedge clk);
        downloading <= 1'b0;
        hold_ack    <= 1'b0;   // req already dropped, no stale read starts
        for (int k = 0; k < `READY_DELAY; k++) begin
            @(negedge clk);
            if (ready) begin
                seq_errors++;
                $display("ready rose %0d cycles after download, too early", k);
            end
            @(posedge clk);
        end
        @(negedge clk);
        if (!ready) begin
            seq_errors++;
            $display("ready not high %0d cycles after download", `READY_DELAY);
        end
        if (main_ok) begin
            seq_errors++;
            $display("main hit right after reload, line was not dropped");
        end
        rises0 = req_rises;
        wait_ok();   // refetch
        if (req_rises == rises0) begin
            seq_errors++;
            $display("no sdram request for the refetch after reload");
        end

        // ack held off, command must stay put
        wait_idle();
        @(posedge clk);
        hold_ack <= 1'b1;
        drive(15'h6000, 1'b1, 13'h1800);
        do @(negedge clk); while (!sdram_cmd.req);
        held = sdram_cmd;
        repeat (8) begin
            @(negedge clk);
            if (sdram_cmd !== held) begin
                seq_errors++;
                $display("CHECK FAILED sdram_cmd got %h expected %h", sdram_cmd, held);
            end
        end
        @(posedge clk);
        hold_ack <= 1'b0;
        wait_ok();
        repeat (4) @(posedge clk);

        $display("errors: data %0d, sequence %0d", data_errors, seq_errors);
        if (data_errors == 0 && seq_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WD_LIMIT) @(posedge clk);
        $display("watchdog expired, the run took too long");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+verilog
verilog/rom_pkg.sv
verilog/rom_request.sv
verilog/rom_arbiter.sv
verilog/rom_bus_top.sv
test/sdram_model.sv
test/rom_bus_checker.sv
test/rom_bus_assert.sv
test/rom_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the rom bus testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f vlog.f --top-module rom_bus_tb -o rom_bus_sim

# keep going on a nonzero sim exit, the log decides
./obj_dir/rom_bus_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi
